/* include/i2c_cfg.svh */
`ifndef I2C_CFG_SVH
`define I2C_CFG_SVH

// Last phase counter value, so one bus phase is this plus one clocks
`define I2C_CLOCK_DIV 15

// Log2 of the transmit FIFO depth
`define I2C_FIFO_AW 4

// Number of 8-bit words in the address bitmap (128 addresses)
`define I2C_ADDR_WORDS 16

// Cycles that SDA is driven high before the pad lets go of it
`define I2C_RELEASE_HIGH 12

`endif

/* src/i2c_pkg.sv */
package i2c_pkg;

	// One transmit FIFO entry.
	// frame_end set means this entry closes a transaction and carries no data
	typedef struct packed {
		logic       frame_end;
		logic [7:0] data;
	} tx_entry_t;

	// Drive of one discrete pad cell
	// pd pulls low, pu_n low drives high, oe enables either of them
	typedef struct packed {
		logic pd;
		logic pu_n;
		logic oe;
	} pad_drive_t;

	// Transmit engine states
	typedef enum logic [3:0] {
		TX_IDLE,
		TX_START,
		TX_SCL_LOW,
		TX_SCL_HIGH,
		TX_ACK_LOW,
		TX_ACK_HIGH,
		TX_STOP0,
		TX_STOP1,
		TX_STOP2
	} tx_state_t;

	// Receive engine states
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_DATA,
		RX_ACK
	} rx_state_t;

endpackage

/* src/tx_fifo.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module tx_fifo import i2c_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  logic      push,
	input  tx_entry_t push_entry,
	input  logic      pop,
	output tx_entry_t head,
	output logic      head_valid,
	output logic      full
);

	localparam int AW    = `I2C_FIFO_AW;
	localparam int DEPTH = 1 << AW;

	tx_entry_t       mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [AW:0]     count;
	logic            do_push;
	logic            do_pop;

	// Pushes into a full buffer and pops from an empty one are dropped
	assign do_push    = push && !full;
	assign do_pop     = pop && head_valid;
	assign full       = (count == (AW+1)'(DEPTH));
	assign head_valid = (count != '0);

	// Head is read straight from the array, no read latency
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

/* src/i2c_tx_engine.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module i2c_tx_engine import i2c_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       tx_req,
	input  logic       rx_busy,
	input  tx_entry_t  head,
	input  logic       head_valid,
	output logic       pop,
	output pad_drive_t scl_drive,
	output pad_drive_t sda_drive
);

	localparam int DIV = `I2C_CLOCK_DIV;
	localparam int CW  = $clog2(2 * DIV + 2);
	localparam int RW  = $clog2(`I2C_RELEASE_HIGH + 1);

	localparam logic [CW-1:0] PHASE_END   = CW'(DIV);
	localparam logic [CW-1:0] START_END   = CW'(2 * DIV);
	localparam logic [CW-1:0] SDA_DELAY   = CW'(DIV / 4);
	localparam logic [RW-1:0] RELEASE_LEN = RW'(`I2C_RELEASE_HIGH);

	localparam pad_drive_t PAD_OFF  = '{pd: 1'b0, pu_n: 1'b1, oe: 1'b0};
	localparam pad_drive_t PAD_HIGH = '{pd: 1'b0, pu_n: 1'b0, oe: 1'b1};

	tx_state_t     state;
	tx_state_t     next_state;
	logic [CW-1:0] phase_cnt;
	logic [2:0]    bit_idx;
	logic [RW-1:0] rel_cnt;
	logic          req_flag;
	logic          req_clear;
	logic          bit_reload;
	logic          bit_step;
	logic          scl_en;
	logic          scl_val;
	logic          sda_en;
	logic          sda_val;

	always_comb begin
		next_state = state;
		req_clear  = 1'b0;
		bit_reload = 1'b0;
		bit_step   = 1'b0;
		pop        = 1'b0;
		scl_en     = 1'b0;
		scl_val    = 1'b1;
		sda_en     = 1'b0;
		sda_val    = 1'b1;

		case (state)
			TX_IDLE: begin
				if (req_flag && !rx_busy)
					next_state = TX_START;
			end
			TX_START: begin
				req_clear  = 1'b1;
				bit_reload = 1'b1;
				scl_en     = 1'b1;
				sda_en     = 1'b1;
				// SDA falls halfway through, unless the frame has no data at all
				if (phase_cnt > PHASE_END) begin
					if (head.frame_end || !head_valid)
						next_state = TX_STOP1;
					else
						sda_val = 1'b0;
				end
				if (phase_cnt == START_END)
					next_state = TX_SCL_LOW;
			end
			TX_SCL_LOW: begin
				scl_en  = 1'b1;
				scl_val = 1'b0;
				sda_en  = 1'b1;
				sda_val = head.data[bit_idx];
				if (phase_cnt == PHASE_END)
					next_state = TX_SCL_HIGH;
			end
			TX_SCL_HIGH: begin
				scl_en  = 1'b1;
				sda_en  = 1'b1;
				sda_val = head.data[bit_idx];
				if (phase_cnt == PHASE_END) begin
					bit_step = 1'b1;
					if (bit_idx != 3'd0)
						next_state = TX_SCL_LOW;
					else
						next_state = TX_ACK_LOW;
				end
			end
			TX_ACK_LOW: begin
				// SDA is left to the receiving device during the acknowledge slot
				scl_en  = 1'b1;
				scl_val = 1'b0;
				if (phase_cnt == PHASE_END) begin
					pop        = 1'b1;
					next_state = TX_ACK_HIGH;
				end
			end
			TX_ACK_HIGH: begin
				scl_en     = 1'b1;
				bit_reload = 1'b1;
				if (phase_cnt == PHASE_END) begin
					if (head_valid && !head.frame_end)
						next_state = TX_SCL_LOW;
					else
						next_state = TX_STOP0;
				end
			end
			TX_STOP0: begin
				scl_en  = 1'b1;
				scl_val = 1'b0;
				sda_en  = 1'b1;
				sda_val = 1'b0;
				if (phase_cnt == PHASE_END)
					next_state = TX_STOP1;
			end
			TX_STOP1: begin
				scl_en  = 1'b1;
				sda_en  = 1'b1;
				sda_val = 1'b0;
				if (phase_cnt == PHASE_END)
					next_state = TX_STOP2;
			end
			TX_STOP2: begin
				scl_en = 1'b1;
				sda_en = 1'b1;
				// Retire the frame marker once the stop is on the bus
				if (phase_cnt == PHASE_END) begin
					pop        = 1'b1;
					next_state = TX_IDLE;
				end
			end
			default: next_state = TX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= TX_IDLE;
			phase_cnt <= '0;
			req_flag  <= 1'b0;
			bit_idx   <= 3'd7;
		end else begin
			state <= next_state;
			if (next_state != state)
				phase_cnt <= '0;
			else
				phase_cnt <= phase_cnt + 1'b1;
			if (req_clear)
				req_flag <= 1'b0;
			else if (tx_req)
				req_flag <= 1'b1;
			if (bit_reload)
				bit_idx <= 3'd7;
			else if (bit_step)
				bit_idx <= bit_idx - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_drive <= PAD_OFF;
			sda_drive <= PAD_OFF;
			rel_cnt   <= RELEASE_LEN;
		end else begin
			scl_drive <= '{pd: scl_en & ~scl_val, pu_n: ~(scl_en & scl_val), oe: scl_en};

			// SDA follows the state a quarter phase late so it never moves at an SCL edge
			if (sda_en) begin
				if (phase_cnt >= SDA_DELAY) begin
					sda_drive <= '{pd: ~sda_val, pu_n: ~sda_val, oe: 1'b1};
					rel_cnt   <= '0;
				end
			end else if (rel_cnt < RELEASE_LEN) begin
				// Pull the line high actively before handing it to the pull-up
				sda_drive <= PAD_HIGH;
				rel_cnt   <= rel_cnt + 1'b1;
			end else begin
				sda_drive <= PAD_OFF;
			end
		end
	end

endmodule

/* src/i2c_rx_engine.sv */
`timescale 1ns/1ps

module i2c_rx_engine import i2c_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       scl_in,
	input  logic       sda_in,
	input  logic       match,
	output logic [7:0] lookup_addr,
	output logic       ack,
	output logic       rx_busy,
	output logic [7:0] rx_char,
	output logic       rx_char_latch,
	output logic       rx_req
);

	rx_state_t  state;
	rx_state_t  next_state;
	logic       scl_meta;
	logic       scl_sync;
	logic       scl_last;
	logic       sda_meta;
	logic       sda_sync;
	logic       sda_last;
	logic [2:0] bit_cnt;
	logic       cnt_clear;
	logic       cnt_incr;
	logic       shift;
	logic       first_byte;
	logic       addr_enable;
	logic       addr_disable;
	logic       ack_set;
	logic       ack_clear;
	logic       next_busy;
	logic       next_char_latch;
	logic       next_req;
	logic       scl_rise;
	logic       scl_fall;
	logic       stop_seen;

	assign scl_rise  = !scl_last && scl_sync;
	assign scl_fall  = scl_last && !scl_sync;
	// Stop is SDA rising while SCL stays high
	assign stop_seen = !sda_last && sda_sync && scl_sync;

	always_comb begin
		next_state      = state;
		next_busy       = 1'b1;
		next_char_latch = 1'b0;
		next_req        = 1'b0;
		cnt_clear       = 1'b0;
		cnt_incr        = 1'b0;
		shift           = 1'b0;
		addr_enable     = 1'b0;
		addr_disable    = 1'b0;
		ack_set         = 1'b0;
		ack_clear       = 1'b0;

		case (state)
			RX_IDLE: begin
				next_busy   = 1'b0;
				cnt_clear   = 1'b1;
				addr_enable = 1'b1;
				ack_clear   = 1'b1;
				if (!sda_sync && scl_sync)
					next_state = RX_DATA;
			end
			RX_DATA: begin
				if (scl_rise) begin
					shift    = 1'b1;
					cnt_incr = 1'b1;
					if (bit_cnt == 3'd7) begin
						cnt_clear       = 1'b1;
						next_char_latch = 1'b1;
						next_state      = RX_ACK;
					end
				end
				if (stop_seen) begin
					next_req   = 1'b1;
					next_state = RX_IDLE;
				end
			end
			RX_ACK: begin
				addr_disable = 1'b1;
				if (stop_seen) begin
					next_req   = 1'b1;
					next_state = RX_IDLE;
				end else if (scl_fall) begin
					// First fall opens the acknowledge slot, the second one closes it
					if (match)
						ack_set = 1'b1;
					cnt_incr = 1'b1;
					if (bit_cnt == 3'd1) begin
						ack_clear  = 1'b1;
						cnt_clear  = 1'b1;
						next_state = RX_DATA;
					end
				end
			end
			default: next_state = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_meta <= 1'b1;
			scl_sync <= 1'b1;
			scl_last <= 1'b1;
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
			sda_last <= 1'b1;
		end else begin
			scl_meta <= scl_in;
			scl_sync <= scl_meta;
			scl_last <= scl_sync;
			sda_meta <= sda_in;
			sda_sync <= sda_meta;
			sda_last <= sda_sync;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= RX_IDLE;
			rx_busy       <= 1'b0;
			rx_char_latch <= 1'b0;
			rx_req        <= 1'b0;
			bit_cnt       <= '0;
			first_byte    <= 1'b1;
			ack           <= 1'b0;
		end else begin
			state         <= next_state;
			rx_busy       <= next_busy;
			rx_char_latch <= next_char_latch;
			rx_req        <= next_req;
			if (cnt_clear)
				bit_cnt <= '0;
			else if (cnt_incr)
				bit_cnt <= bit_cnt + 1'b1;
			if (addr_enable)
				first_byte <= 1'b1;
			else if (addr_disable)
				first_byte <= 1'b0;
			if (ack_clear)
				ack <= 1'b0;
			else if (ack_set)
				ack <= 1'b1;
		end
	end

	// The first byte after a start is the address, kept for the whole transaction
	always_ff @(posedge clk) begin
		if (shift)
			rx_char <= {rx_char[6:0], sda_sync};
		if (shift && first_byte)
			lookup_addr <= {lookup_addr[6:0], sda_sync};
	end

endmodule

/* src/addr_match_ram.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module addr_match_ram (
	input  logic       clk,
	input  logic       reset,
	input  logic [7:0] load_char,
	input  logic       load_latch,
	input  logic       load_reset,
	input  logic [7:0] lookup_addr,
	output logic       match
);

	localparam int WORDS = `I2C_ADDR_WORDS;
	localparam int AW    = $clog2(WORDS);

	logic [7:0]    bitmap [WORDS];
	logic [AW-1:0] load_ptr;
	logic [7:0]    lookup_word;

	// Words are loaded in order, address 0 first
	always_ff @(posedge clk) begin
		if (load_latch)
			bitmap[load_ptr] <= load_char;
	end

	always_ff @(posedge clk) begin
		if (reset || load_reset)
			load_ptr <= '0;
		else if (load_latch)
			load_ptr <= load_ptr + 1'b1;
	end

	// Upper nibble picks the word, bits 3:1 pick the bit; the R/W bit is ignored
	assign lookup_word = bitmap[lookup_addr[7:4]];
	assign match       = lookup_word[lookup_addr[3:1]];

endmodule

/* src/i2c_discrete_top.sv */
`timescale 1ns/1ps

module i2c_discrete_top import i2c_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       scl_in,
	input  logic       sda_in,
	output pad_drive_t scl_pad,
	output pad_drive_t sda_pad,
	input  logic [7:0] tx_char,
	input  logic       tx_char_latch,
	input  logic       tx_req,
	output logic       tx_full,
	input  logic [7:0] addr_load_char,
	input  logic       addr_load_latch,
	input  logic       addr_load_reset,
	output logic [7:0] rx_char,
	output logic       rx_char_latch,
	output logic       rx_req
);

	localparam pad_drive_t PAD_ACK = '{pd: 1'b1, pu_n: 1'b1, oe: 1'b1};

	tx_entry_t  push_entry;
	tx_entry_t  head;
	logic       head_valid;
	logic       pop;
	logic       rx_busy;
	logic       ack;
	logic       match;
	logic [7:0] lookup_addr;
	pad_drive_t sda_drive;

	// A frame request travels through the FIFO as a marker entry behind its bytes
	assign push_entry = '{frame_end: tx_req, data: tx_char};

	tx_fifo u_tx_fifo (
		.clk        (clk),
		.reset      (reset),
		.push       (tx_char_latch | tx_req),
		.push_entry (push_entry),
		.pop        (pop),
		.head       (head),
		.head_valid (head_valid),
		.full       (tx_full)
	);

	i2c_tx_engine u_i2c_tx_engine (
		.clk        (clk),
		.reset      (reset),
		.tx_req     (tx_req),
		.rx_busy    (rx_busy),
		.head       (head),
		.head_valid (head_valid),
		.pop        (pop),
		.scl_drive  (scl_pad),
		.sda_drive  (sda_drive)
	);

	i2c_rx_engine u_i2c_rx_engine (
		.clk           (clk),
		.reset         (reset),
		.scl_in        (scl_in),
		.sda_in        (sda_in),
		.match         (match),
		.lookup_addr   (lookup_addr),
		.ack           (ack),
		.rx_busy       (rx_busy),
		.rx_char       (rx_char),
		.rx_char_latch (rx_char_latch),
		.rx_req        (rx_req)
	);

	addr_match_ram u_addr_match_ram (
		.clk         (clk),
		.reset       (reset),
		.load_char   (addr_load_char),
		.load_latch  (addr_load_latch),
		.load_reset  (addr_load_reset),
		.lookup_addr (lookup_addr),
		.match       (match)
	);

	// Acknowledge wins over whatever the transmitter drives on SDA
	assign sda_pad = ack ? PAD_ACK : sda_drive;

endmodule

/* dv/i2c_checker.sv */
`timescale 1ns/1ps

module i2c_checker import i2c_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       scl,
	input  logic       sda,
	input  pad_drive_t scl_pad,
	input  pad_drive_t sda_pad,
	input  logic       tx_full,
	input  logic [7:0] rx_char,
	input  logic       rx_char_latch,
	input  logic       rx_req,
	input  logic       ext_active,
	input  logic       quiet,
	output int         errors
);

	localparam logic [1:0] KIND_START = 2'd0;
	localparam logic [1:0] KIND_BYTE  = 2'd1;
	localparam logic [1:0] KIND_STOP  = 2'd2;

	// Expected bus events as {kind, ack, data}
	logic [10:0] exp_q [$];
	logic [7:0]  rx_pending [$];
	logic        prev_scl;
	logic        prev_sda;
	logic [3:0]  bit_cnt;
	logic [7:0]  shreg;
	logic        had_byte;
	logic        prio_reported;
	logic        full_reported;
	int          stops;
	int          reqs;

	initial errors = 0;

	task expect_event(input logic [1:0] kind, input logic ack, input logic [7:0] data);
		exp_q.push_back({kind, ack, data});
	endtask

	task check_event(input logic [1:0] kind, input logic ack, input logic [7:0] data);
		logic [10:0] exp;
		if (exp_q.size() == 0) begin
			$display("At %0t the bus showed an event of kind %0d that nobody expected", $time, kind);
			errors++;
		end else begin
			exp = exp_q.pop_front();
			if (exp[10:9] != kind) begin
				$display("Error at %0t: bus_event expected %0d got %0d", $time, exp[10:9], kind);
				errors++;
			end else if (kind == KIND_BYTE) begin
				if (exp[7:0] != data) begin
					$display("Error at %0t: bus_byte expected %h got %h", $time, exp[7:0], data);
					errors++;
				end
				if (exp[8] != ack) begin
					$display("Error at %0t: bus_ack expected %b got %b", $time, exp[8], ack);
					errors++;
				end
			end
		end
	endtask

	task final_check();
		if (exp_q.size() != 0) begin
			$display("%0d expected bus events never appeared on the bus", exp_q.size());
			errors++;
		end
		if (stops != reqs) begin
			$display("Error at %0t: rx_req expected %0d got %0d", $time, stops, reqs);
			errors++;
		end
	endtask

	always @(posedge clk) begin
		if (reset) begin
			prev_scl      <= 1'b1;
			prev_sda      <= 1'b1;
			bit_cnt       <= '0;
			had_byte      <= 1'b0;
			prio_reported <= 1'b0;
			full_reported <= 1'b0;
			stops         <= 0;
			reqs          <= 0;
		end else begin
			prev_scl <= scl;
			prev_sda <= sda;
			if (prev_scl && scl && prev_sda && !sda) begin
				check_event(KIND_START, 1'b0, 8'h00);
				bit_cnt  <= '0;
				had_byte <= 1'b0;
			end else if (prev_scl && scl && !prev_sda && sda) begin
				check_event(KIND_STOP, 1'b0, 8'h00);
				// One SCL pulse leads into a stop after a byte, none after a bare start
				if (bit_cnt != {3'd0, had_byte}) begin
					$display("Error at %0t: scl_pulses expected %0d got %0d",
						$time, had_byte, bit_cnt);
					errors++;
				end
				stops <= stops + 1;
			end else if (!prev_scl && scl) begin
				if (bit_cnt == 4'd8) begin
					check_event(KIND_BYTE, sda, shreg);
					bit_cnt  <= '0;
					had_byte <= 1'b1;
				end else begin
					shreg <= {shreg[6:0], sda};
					if (bit_cnt == 4'd7)
						rx_pending.push_back({shreg[6:0], sda});
					bit_cnt <= bit_cnt + 4'd1;
				end
			end

			if (rx_char_latch) begin
				if (rx_pending.size() == 0) begin
					$display("At %0t rx_char_latch pulsed with no byte on the bus", $time);
					errors++;
				end else if (rx_pending[0] != rx_char) begin
					$display("Error at %0t: rx_char expected %h got %h", $time, rx_pending[0], rx_char);
					errors++;
					void'(rx_pending.pop_front());
				end else begin
					void'(rx_pending.pop_front());
				end
			end
			if (rx_req) begin
				reqs <= reqs + 1;
				if (rx_pending.size() != 0) begin
					$display("At %0t rx_req came before every byte was delivered", $time);
					errors++;
				end
			end

			// Nothing may move before the first request
			if (quiet && (scl_pad.oe || sda_pad.oe || rx_char_latch || rx_req)) begin
				$display("At %0t the DUT was active before any request", $time);
				errors++;
			end
			if (!ext_active)
				prio_reported <= 1'b0;
			else if (scl_pad.oe && !prio_reported) begin
				$display("At %0t the DUT drove SCL during an external transaction", $time);
				errors++;
				prio_reported <= 1'b1;
			end

			// A pad driving high must never meet a line that is pulled low
			if (scl_pad.oe && !scl_pad.pu_n && !scl) begin
				$display("At %0t the DUT drove SCL high while the line was low", $time);
				errors++;
			end
			if (sda_pad.oe && !sda_pad.pu_n && !sda) begin
				$display("At %0t the DUT drove SDA high while the line was low", $time);
				errors++;
			end

			// At most seven entries wait in the FIFO, well below its depth
			if (tx_full && !full_reported) begin
				$display("Error at %0t: tx_full expected 0 got 1", $time);
				errors++;
				full_reported <= 1'b1;
			end
		end
	end

endmodule

/* dv/i2c_tb.sv */
`timescale 1ns/1ps
`include "i2c_cfg.svh"

module i2c_tb import i2c_pkg::*;;

	localparam int PHASE        = `I2C_CLOCK_DIV + 1;
	localparam int N_TX         = 12;
	localparam int N_EXT        = 8;
	localparam int N_FRAMES     = 1 + N_TX + 2 * N_EXT;
	localparam int FRAME_CYCLES = (2 + 6 * 18 + 3) * PHASE + 200;

	logic         clk = 1'b0;
	logic         reset;
	logic [7:0]   tx_char;
	logic         tx_char_latch;
	logic         tx_req;
	logic         tx_full;
	logic [7:0]   addr_load_char;
	logic         addr_load_latch;
	logic         addr_load_reset;
	logic [7:0]   rx_char;
	logic         rx_char_latch;
	logic         rx_req;
	pad_drive_t   scl_pad;
	pad_drive_t   sda_pad;
	logic         m_scl_low;
	logic         m_sda_low;
	logic         ext_active;
	logic         quiet;
	logic         scl;
	logic         sda;
	// One flag per 7-bit address, entry 8*w+b comes from bit b of load word w
	logic [127:0] addr_bits;
	// Bytes of the frame in the FIFO as {ack, data}
	logic [8:0]   frame_bytes [$];
	int           req_count;
	int           req_target;
	int           errors;

	always #2 clk = ~clk;

	// Open-drain bus, low when either side pulls down
	assign scl = !((scl_pad.oe && scl_pad.pd) || m_scl_low);
	assign sda = !((sda_pad.oe && sda_pad.pd) || m_sda_low);

	i2c_discrete_top u_i2c_discrete_top (
		.clk             (clk),
		.reset           (reset),
		.scl_in          (scl),
		.sda_in          (sda),
		.scl_pad         (scl_pad),
		.sda_pad         (sda_pad),
		.tx_char         (tx_char),
		.tx_char_latch   (tx_char_latch),
		.tx_req          (tx_req),
		.tx_full         (tx_full),
		.addr_load_char  (addr_load_char),
		.addr_load_latch (addr_load_latch),
		.addr_load_reset (addr_load_reset),
		.rx_char         (rx_char),
		.rx_char_latch   (rx_char_latch),
		.rx_req          (rx_req)
	);

	i2c_checker u_checker (
		.clk           (clk),
		.reset         (reset),
		.scl           (scl),
		.sda           (sda),
		.scl_pad       (scl_pad),
		.sda_pad       (sda_pad),
		.tx_full       (tx_full),
		.rx_char       (rx_char),
		.rx_char_latch (rx_char_latch),
		.rx_req        (rx_req),
		.ext_active    (ext_active),
		.quiet         (quiet),
		.errors        (errors)
	);

	always @(posedge clk) begin
		if (reset)
			req_count <= 0;
		else if (rx_req)
			req_count <= req_count + 1;
	end

	// The 7-bit address above the R/W bit selects one bitmap entry
	function automatic logic addr_matches(input logic [7:0] a);
		return addr_bits[a[7:1]];
	endfunction

	task wait_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task wait_transactions();
		while (req_count < req_target)
			@(posedge clk);
		wait_cycles(40);
	endtask

	task pulse_tx_req();
		@(posedge clk);
		tx_req <= 1'b1;
		@(posedge clk);
		tx_req <= 1'b0;
	endtask

	// Queues a frame in the FIFO and records the bytes it should show on the bus
	task queue_frame(input int n);
		logic [7:0] data;
		logic       ack;
		for (int i = 0; i < n; i++) begin
			data = 8'($urandom);
			if (i == 0)
				ack = !addr_matches(data);
			frame_bytes.push_back({ack, data});
			@(posedge clk);
			while (tx_full)
				@(posedge clk);
			tx_char       <= data;
			tx_char_latch <= 1'b1;
			@(posedge clk);
			tx_char_latch <= 1'b0;
		end
	endtask

	// Hands the queued frame to the checker as start, bytes and stop
	task expect_frame();
		u_checker.expect_event(2'd0, 1'b0, 8'h00);
		foreach (frame_bytes[i])
			u_checker.expect_event(2'd1, frame_bytes[i][8], frame_bytes[i][7:0]);
		u_checker.expect_event(2'd2, 1'b0, 8'h00);
		frame_bytes.delete();
	endtask

	task master_transaction(input int n, input logic with_req);
		logic [7:0] data;
		logic       ack;
		u_checker.expect_event(2'd0, 1'b0, 8'h00);
		ext_active <= 1'b1;
		wait_cycles(PHASE / 2);
		m_sda_low <= 1'b1;
		wait_cycles(PHASE);
		m_scl_low <= 1'b1;
		for (int i = 0; i < n; i++) begin
			data = 8'($urandom);
			if (i == 0)
				ack = !addr_matches(data);
			u_checker.expect_event(2'd1, ack, data);
			for (int b = 7; b >= 0; b--) begin
				wait_cycles(PHASE / 2);
				m_sda_low <= !data[b];
				wait_cycles(PHASE / 2);
				m_scl_low <= 1'b0;
				wait_cycles(PHASE);
				m_scl_low <= 1'b1;
			end
			wait_cycles(PHASE / 2);
			m_sda_low <= 1'b0;
			wait_cycles(PHASE / 2);
			m_scl_low <= 1'b0;
			wait_cycles(PHASE);
			m_scl_low <= 1'b1;
			if (i == 0 && with_req)
				pulse_tx_req();
		end
		wait_cycles(PHASE / 2);
		m_sda_low <= 1'b1;
		wait_cycles(PHASE / 2);
		m_scl_low <= 1'b0;
		wait_cycles(PHASE / 2);
		// The transaction is over once the stop is on the bus
		m_sda_low  <= 1'b0;
		ext_active <= 1'b0;
		u_checker.expect_event(2'd2, 1'b0, 8'h00);
		wait_cycles(PHASE / 2);
	endtask

	initial begin
		void'($urandom(57650));
		reset           = 1'b1;
		tx_char         = 8'h00;
		tx_char_latch   = 1'b0;
		tx_req          = 1'b0;
		addr_load_char  = 8'h00;
		addr_load_latch = 1'b0;
		addr_load_reset = 1'b0;
		m_scl_low       = 1'b0;
		m_sda_low       = 1'b0;
		ext_active      = 1'b0;
		quiet           = 1'b1;
		req_target      = 0;
		wait_cycles(2);
		reset <= 1'b0;
		wait_cycles(20);

		// Random address bitmap, loaded word by word from the start
		@(posedge clk);
		addr_load_reset <= 1'b1;
		@(posedge clk);
		addr_load_reset <= 1'b0;
		for (int w = 0; w < 16; w++) begin
			addr_bits[w*8 +: 8] = 8'($urandom);
			@(posedge clk);
			addr_load_char  <= addr_bits[w*8 +: 8];
			addr_load_latch <= 1'b1;
			@(posedge clk);
			addr_load_latch <= 1'b0;
		end
		wait_cycles(10);
		quiet <= 1'b0;

		// A request with no bytes
		queue_frame(0);
		expect_frame();
		pulse_tx_req();
		req_target += 1;
		wait_transactions();

		for (int f = 0; f < N_TX; f++) begin
			queue_frame($urandom_range(1, 6));
			expect_frame();
			pulse_tx_req();
			req_target += 1;
			wait_transactions();
		end

		// External traffic, every other one with a frame waiting behind it
		for (int f = 0; f < N_EXT; f++) begin
			if (f % 2 == 0) begin
				master_transaction($urandom_range(1, 4), 1'b0);
				req_target += 1;
			end else begin
				queue_frame($urandom_range(1, 4));
				master_transaction($urandom_range(1, 4), 1'b1);
				expect_frame();
				req_target += 2;
			end
			wait_transactions();
		end

		u_checker.final_check();
		wait_cycles(2);
		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		#(N_FRAMES * FRAME_CYCLES * 2 * 4);
		$display("Timeout: the DUT did not finish its transactions in time");
		$display("Test failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
src/i2c_pkg.sv
src/tx_fifo.sv
src/i2c_tx_engine.sv
src/i2c_rx_engine.sv
src/addr_match_ram.sv
src/i2c_discrete_top.sv
dv/i2c_checker.sv
dv/i2c_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the I2C testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module i2c_tb -o i2c_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/i2c_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" "$LOG"; then
	exit 1
fi
exit 0
